/* design/pollable_memory_pkg.sv */
//--------------------------------------------------------------------
// pollable memory shared definitions
// bus and memory widths, filter delays, bus-side types and FSM states
//--------------------------------------------------------------------
package pollable_memory_pkg;

	// bus and memory geometry
	localparam int bus_width          = 16;
	localparam int halfwords_per_word = 2;
	localparam int address_depth      = 8;  // reduced for simulation
	localparam int byte_address_depth = 10;

	// delay line lengths in clock cycles
	localparam int filter_depth        = 10;
	localparam int enable_filter_depth = 20;
	localparam int ack_delay           = 30;

	// half-open playback byte range
	localparam int play_start_byte = 0;
	localparam int play_end_byte   = 64;

	typedef logic [bus_width-1:0]                    bus_word_t;
	typedef logic [halfwords_per_word*bus_width-1:0] data_word_t;
	typedef logic [address_depth-1:0]                word_address_t;
	typedef logic [byte_address_depth-1:0]           byte_address_t;
	typedef logic [7:0]                              play_byte_t;
	typedef logic [$clog2(halfwords_per_word)-1:0]   halfword_index_t;

	// most significant halfword travels first
	localparam halfword_index_t msb_halfword = halfword_index_t'(halfwords_per_word - 1);

	typedef enum logic [1:0] {
		idle,
		latched,
		done
	} bus_phase_t;

	// filtered host levels
	typedef struct packed {
		logic      enable_on;
		logic      enable_off;
		logic      read_on;
		logic      read_off;
		logic      select_data_on;
		logic      select_data_off;
		bus_word_t bus_data;
	} host_request_t;

	typedef struct packed {
		logic            load_address;
		logic            load_halfword;
		logic            advance_address;
		halfword_index_t halfword_index;
		logic            capture_read;
	} word_command_t;

endpackage

/* design/bus_input_filter.sv */
//--------------------------------------------------------------------
// host input filter
// delays the control lines and the bus, and decodes a level only
// when the last two stages of a delay line agree
//--------------------------------------------------------------------
`timescale 1ns/1ps

module bus_input_filter (
	input  logic                               clock,
	input  logic                               reset125,
	input  logic                               read,
	input  logic                               register_select,
	input  logic                               enable,
	input  pollable_memory_pkg::bus_word_t     bus_in,
	output pollable_memory_pkg::host_request_t request
);
	import pollable_memory_pkg::*;

	logic [filter_depth-1:0]        read_line;
	logic [filter_depth-1:0]        select_line;
	logic [enable_filter_depth-1:0] enable_line; // longer, so bus and mode settle first
	bus_word_t                      bus_line [filter_depth];

	always_ff @(posedge clock) begin
		if (reset125) begin
			read_line <= '0;
			select_line <= '0;
			enable_line <= '0;
			for (int i = 0; i < filter_depth; i++) begin
				bus_line[i] <= '0;
			end
		end else begin
			read_line <= {read_line[filter_depth-2:0], read};
			select_line <= {select_line[filter_depth-2:0], register_select};
			enable_line <= {enable_line[enable_filter_depth-2:0], enable};
			bus_line[0] <= bus_in;
			for (int i = 1; i < filter_depth; i++) begin
				bus_line[i] <= bus_line[i-1];
			end
		end
	end

	// ------------------------------------------------------------------
	// two-stage agreement so a single-cycle glitch gives neither level
	// ------------------------------------------------------------------
	always_comb begin
		request.enable_on = &enable_line[enable_filter_depth-1 -: 2];
		request.enable_off = ~|enable_line[enable_filter_depth-1 -: 2];
		request.read_on = &read_line[filter_depth-1 -: 2];
		request.read_off = ~|read_line[filter_depth-1 -: 2];
		request.select_data_on = &select_line[filter_depth-1 -: 2];   // data register
		request.select_data_off = ~|select_line[filter_depth-1 -: 2]; // address register
		request.bus_data = bus_line[filter_depth-1];
	end

endmodule

/* design/bus_transaction_fsm.sv */
//--------------------------------------------------------------------
// bus transaction FSM
// address, write and read phases with halfword counters, abort of
// stale partial phases, write strobe and the delayed acknowledge
//--------------------------------------------------------------------
`timescale 1ns/1ps

module bus_transaction_fsm (
	input  logic                               clock,
	input  logic                               reset125,
	input  pollable_memory_pkg::host_request_t request,
	output pollable_memory_pkg::word_command_t command,
	output logic                               write_strobe,
	output logic                               ack_valid
);
	import pollable_memory_pkg::*;

	bus_phase_t      address_phase;
	bus_phase_t      write_phase;
	bus_phase_t      read_phase;
	halfword_index_t write_index;
	halfword_index_t read_index;
	logic            read_mode;
	logic            write_mode;
	logic            address_mode;
	logic            access;
	logic            pre_ack;
	logic [ack_delay-1:0] ack_line;

	assign read_mode = request.read_on;
	assign write_mode = request.read_off && request.select_data_on;
	assign address_mode = request.read_off && request.select_data_off;
	assign access = request.enable_on && (read_mode || write_mode || address_mode);

	// ------------------------------------------------------------------
	// phase state
	// ------------------------------------------------------------------
	always_ff @(posedge clock) begin
		write_strobe <= 1'b0;
		if (reset125) begin
			address_phase <= idle;
			write_phase <= idle;
			read_phase <= idle;
			write_index <= msb_halfword;
			read_index <= msb_halfword;
		end else if (request.enable_on) begin
			// each phase latches once per enable period
			if (read_mode && read_phase == idle) begin
				read_phase <= latched;
			end
			if (write_mode && write_phase == idle) begin
				write_phase <= latched;
			end
			if (address_mode && address_phase == idle) begin
				address_phase <= latched;
			end
		end else if (request.enable_off) begin
			if (write_phase != idle) begin
				read_phase <= idle;      // abort other phases
				read_index <= msb_halfword;
				address_phase <= idle;
				if (write_phase == done) begin
					write_phase <= idle;
					write_index <= msb_halfword;
				end else if (write_index != '0) begin
					write_phase <= idle;
					write_index <= write_index - 1'b1;
				end else begin
					write_phase <= done; // word complete
					write_strobe <= 1'b1;
				end
			end
			if (read_phase != idle) begin
				write_phase <= idle;
				write_index <= msb_halfword;
				address_phase <= idle;
				if (read_phase == done) begin
					read_phase <= idle;
					read_index <= msb_halfword;
				end else if (read_index != '0) begin
					read_phase <= idle;
					read_index <= read_index - 1'b1;
				end else begin
					read_phase <= done;
				end
			end
			if (address_phase != idle) begin
				write_phase <= idle;
				write_index <= msb_halfword;
				read_phase <= idle;
				read_index <= msb_halfword;
				// the address word is a single halfword
				address_phase <= (address_phase == done) ? idle : done;
			end
		end
	end

	// ------------------------------------------------------------------
	// commands to the word datapath
	// ------------------------------------------------------------------
	always_comb begin
		command = '0;
		command.halfword_index = read_mode ? read_index : write_index;
		if (request.enable_on) begin
			command.capture_read = read_mode && read_phase == idle;
			command.load_halfword = write_mode && write_phase == idle;
		end else if (request.enable_off) begin
			// host keeps the bus until ack_valid falls
			command.load_address = address_phase == done;
			command.advance_address = write_phase == done || read_phase == done;
		end
	end

	// ------------------------------------------------------------------
	// acknowledge delay line
	// ------------------------------------------------------------------
	always_ff @(posedge clock) begin
		if (reset125) begin
			pre_ack <= 1'b0;
			ack_line <= '0;
		end else begin
			pre_ack <= access;
			ack_line <= {ack_line[ack_delay-2:0], pre_ack};
		end
	end

	assign ack_valid = ack_line[ack_delay-1];

endmodule

/* design/word_assembler.sv */
//--------------------------------------------------------------------
// word assembler
// address register with autoincrement, write word assembly from
// halfwords and selection of the read halfword for the bus
//--------------------------------------------------------------------
`timescale 1ns/1ps

module word_assembler (
	input  logic                               clock,
	input  logic                               reset125,
	input  pollable_memory_pkg::word_command_t command,
	input  pollable_memory_pkg::bus_word_t     bus_data,
	input  pollable_memory_pkg::data_word_t    read_word,
	output pollable_memory_pkg::word_address_t word_address,
	output pollable_memory_pkg::data_word_t    write_word,
	output pollable_memory_pkg::bus_word_t     bus_out
);
	import pollable_memory_pkg::*;

	// ------------------------------------------------------------------
	// address and read halfword
	// ------------------------------------------------------------------
	always_ff @(posedge clock) begin
		if (reset125) begin
			word_address <= '0;
			bus_out <= '0;
		end else begin
			if (command.load_address) begin
				word_address <= bus_data[address_depth-1:0]; // low bits of the halfword
			end else if (command.advance_address) begin
				word_address <= word_address + 1'b1;
			end
			if (command.capture_read) begin
				bus_out <= read_word[command.halfword_index*bus_width +: bus_width];
			end
		end
	end

	// write word payload
	always_ff @(posedge clock) begin
		if (command.load_halfword) begin
			write_word[command.halfword_index*bus_width +: bus_width] <= bus_data;
		end
	end

endmodule

/* design/gearbox_ram.sv */
//--------------------------------------------------------------------
// gearbox memory
// dual port RAM with whole words on the bus side and bytes for playback
//--------------------------------------------------------------------
`timescale 1ns/1ps

module gearbox_ram (
	input  logic                               clock,
	input  logic                               write_strobe,
	input  pollable_memory_pkg::word_address_t word_address,
	input  pollable_memory_pkg::data_word_t    write_word,
	output pollable_memory_pkg::data_word_t    read_word,
	input  pollable_memory_pkg::byte_address_t byte_address,
	output pollable_memory_pkg::play_byte_t    play_byte
);
	import pollable_memory_pkg::*;

	localparam int byte_select_bits = byte_address_depth - address_depth;

	data_word_t    memory [2**address_depth];
	word_address_t play_word_address;
	logic [byte_select_bits-1:0] byte_select;

	assign play_word_address = byte_address[byte_address_depth-1:byte_select_bits];
	assign byte_select = byte_address[byte_select_bits-1:0]; // 0 is the low byte

	// port A reads before it writes
	always_ff @(posedge clock) begin
		if (write_strobe) begin
			memory[word_address] <= write_word;
		end
		read_word <= memory[word_address];
	end

	// port B
	always_ff @(posedge clock) begin
		play_byte <= memory[play_word_address][byte_select*8 +: 8];
	end

endmodule

/* design/playback_counter.sv */
//--------------------------------------------------------------------
// playback counter
// loops the byte address over the playback range, sync at each wrap
//--------------------------------------------------------------------
`timescale 1ns/1ps

module playback_counter (
	input  logic                               clock,
	input  logic                               reset125,
	output pollable_memory_pkg::byte_address_t byte_address,
	output logic                               sync_pulse
);
	import pollable_memory_pkg::*;

	localparam byte_address_t first_byte = byte_address_t'(play_start_byte);
	localparam byte_address_t last_byte = byte_address_t'(play_end_byte - 1);

	logic wrapped; // high while the address sits on the first byte after a wrap

	always_ff @(posedge clock) begin
		if (reset125) begin
			byte_address <= first_byte;
			wrapped <= 1'b0;
			sync_pulse <= 1'b0;
		end else begin
			wrapped <= 1'b0;
			if (byte_address == last_byte) begin
				byte_address <= first_byte;
				wrapped <= 1'b1;
			end else begin
				byte_address <= byte_address + 1'b1;
			end
			sync_pulse <= wrapped; // one more stage to match the RAM read
		end
	end

endmodule

/* design/pollable_memory.sv */
//--------------------------------------------------------------------
// pollable memory top level
// parallel bus slave into a dual port pattern memory with playback
//--------------------------------------------------------------------
`timescale 1ns/1ps

module pollable_memory (
	input  logic                            clock,
	input  logic                            reset125,
	input  logic                            read,            // high for read
	input  logic                            register_select, // high for data
	input  logic                            enable,
	input  pollable_memory_pkg::bus_word_t  bus_in,
	output pollable_memory_pkg::bus_word_t  bus_out,
	output logic                            bus_drive,
	output logic                            ack_valid,
	output logic                            sync_pulse,
	output pollable_memory_pkg::play_byte_t play_byte
);
	import pollable_memory_pkg::*;

	host_request_t request;
	word_command_t command;
	logic          write_strobe;
	word_address_t word_address;
	data_word_t    write_word;
	data_word_t    read_word;
	byte_address_t byte_address;

	assign bus_drive = read; // slave drives the bus for the whole read

	bus_input_filter filter (
		.clock           (clock),
		.reset125        (reset125),
		.read            (read),
		.register_select (register_select),
		.enable          (enable),
		.bus_in          (bus_in),
		.request         (request)
	);

	bus_transaction_fsm fsm (
		.clock        (clock),
		.reset125     (reset125),
		.request      (request),
		.command      (command),
		.write_strobe (write_strobe),
		.ack_valid    (ack_valid)
	);

	word_assembler assembler (
		.clock        (clock),
		.reset125     (reset125),
		.command      (command),
		.bus_data     (request.bus_data),
		.read_word    (read_word),
		.word_address (word_address),
		.write_word   (write_word),
		.bus_out      (bus_out)
	);

	gearbox_ram ram (
		.clock        (clock),
		.write_strobe (write_strobe),
		.word_address (word_address),
		.write_word   (write_word),
		.read_word    (read_word),
		.byte_address (byte_address),
		.play_byte    (play_byte)
	);

	playback_counter playback (
		.clock        (clock),
		.reset125     (reset125),
		.byte_address (byte_address),
		.sync_pulse   (sync_pulse)
	);

endmodule

/* testbench/pollable_memory_checker.sv */
//--------------------------------------------------------------------
// pollable memory checker
// watches the DUT ports, compares reads and playback with the
// expected values from the testbench and counts errors
//--------------------------------------------------------------------
`timescale 1ns/1ps

module pollable_memory_checker (
	input  logic                                clock,
	input  logic                                reset125,
	input  logic                                enable,
	input  logic                                read,
	input  logic                                ack_valid,
	input  logic                                bus_drive,
	input  pollable_memory_pkg::bus_word_t      bus_out,
	input  logic                                sync_pulse,
	input  pollable_memory_pkg::play_byte_t     play_byte,
	input  pollable_memory_pkg::bus_word_t      expected_halfword,
	input  logic [8*24-1:0]                     test_name,
	input  logic                                play_arm,
	input  logic [8*(pollable_memory_pkg::play_end_byte -
		pollable_memory_pkg::play_start_byte)-1:0] play_image,
	output int                                  idle_errors,
	output int                                  read_errors,
	output int                                  play_errors,
	output int                                  sync_errors,
	output int                                  reads_checked,
	output logic                                play_done
);
	import pollable_memory_pkg::*;

	logic ack_prev;
	logic access_seen; // first enable after reset

	task automatic report_mismatch(input logic [8*24-1:0] name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("[FAIL] %0s expected %h actual %h", name, expected, actual);
	endtask

	// ------------------------------------------------------------------
	// quiet outputs after reset and read data at each acknowledge
	// ------------------------------------------------------------------
	always @(negedge clock) begin
		if (reset125) begin
			ack_prev = 1'b0;
			access_seen = 1'b0;
		end else begin
			if (enable === 1'b1) begin
				access_seen = 1'b1;
			end
			if (!access_seen) begin
				if (ack_valid !== 1'b0) begin
					report_mismatch("after_reset ack_valid", 32'h0, 32'(ack_valid));
					idle_errors++;
				end
				if (bus_out !== '0) begin
					report_mismatch("after_reset bus_out", 32'h0, 32'(bus_out));
					idle_errors++;
				end
				if (sync_pulse !== 1'b0) begin
					report_mismatch("after_reset sync_pulse", 32'h0, 32'(sync_pulse));
					idle_errors++;
				end
			end
			if (ack_valid === 1'b1 && !ack_prev) begin
				if (bus_drive !== read) begin // bus_drive follows the read line
					report_mismatch(test_name, 32'(read), 32'(bus_drive));
					read_errors++;
				end
				if (read === 1'b1) begin
					reads_checked++;
					if (bus_out !== expected_halfword) begin
						report_mismatch(test_name, 32'(expected_halfword), 32'(bus_out));
						read_errors++;
					end
				end
			end
			ack_prev = (ack_valid === 1'b1);
		end
	end

	// ------------------------------------------------------------------
	// playback aligned on sync_pulse
	// ------------------------------------------------------------------
	initial begin
		play_done = 1'b0;
		wait (play_arm === 1'b1);
		do @(negedge clock); while (sync_pulse !== 1'b1);
		for (int b = 0; b < play_end_byte - play_start_byte; b++) begin
			if (b > 0) begin
				@(negedge clock);
				if (sync_pulse !== 1'b0) begin // no sync inside the loop
					report_mismatch("sync_period", 32'h0, 32'(sync_pulse));
					sync_errors++;
				end
			end
			if (play_byte !== play_image[b*8 +: 8]) begin
				report_mismatch("playback", 32'(play_image[b*8 +: 8]), 32'(play_byte));
				play_errors++;
			end
		end
		@(negedge clock);
		if (sync_pulse !== 1'b1) begin
			report_mismatch("sync_period", 32'h1, 32'(sync_pulse));
			sync_errors++;
		end
		play_done = 1'b1;
	end

endmodule

/* testbench/pollable_memory_tb.sv */
//--------------------------------------------------------------------
// pollable memory testbench
// table of bus steps with a model memory and a playback check at the end
//--------------------------------------------------------------------
`timescale 1ns/1ps

module pollable_memory_tb;
	import pollable_memory_pkg::*;

	typedef logic [8*24-1:0] label_t;

	typedef struct packed {
		logic      read;
		logic      register_select; // high for data
		bus_word_t value;
		bus_word_t expected;        // reads only
		label_t    name;
	} step_t;

	logic          clock;
	logic          reset125;
	logic          read;
	logic          register_select;
	logic          enable;
	bus_word_t     bus_in;
	bus_word_t     bus_out;
	logic          bus_drive;
	logic          ack_valid;
	logic          sync_pulse;
	play_byte_t    play_byte;
	bus_word_t     expected_halfword;
	label_t        current_name;
	logic          play_arm;
	logic          play_done;
	logic          table_ready;
	logic [8*(play_end_byte-play_start_byte)-1:0] play_image;
	int            idle_errors;
	int            read_errors;
	int            play_errors;
	int            sync_errors;
	int            reads_checked;
	int            expected_reads;
	int            count_errors;
	logic [31:0]   lcg_state;
	step_t         steps [$];
	data_word_t    model_memory [2**address_depth];
	word_address_t model_address;

	pollable_memory DUT (
		.clock           (clock),
		.reset125        (reset125),
		.read            (read),
		.register_select (register_select),
		.enable          (enable),
		.bus_in          (bus_in),
		.bus_out         (bus_out),
		.bus_drive       (bus_drive),
		.ack_valid       (ack_valid),
		.sync_pulse      (sync_pulse),
		.play_byte       (play_byte)
	);

	pollable_memory_checker scoreboard (
		.clock             (clock),
		.reset125          (reset125),
		.enable            (enable),
		.read              (read),
		.ack_valid         (ack_valid),
		.bus_drive         (bus_drive),
		.bus_out           (bus_out),
		.sync_pulse        (sync_pulse),
		.play_byte         (play_byte),
		.expected_halfword (expected_halfword),
		.test_name         (current_name),
		.play_arm          (play_arm),
		.play_image        (play_image),
		.idle_errors       (idle_errors),
		.read_errors       (read_errors),
		.play_errors       (play_errors),
		.sync_errors       (sync_errors),
		.reads_checked     (reads_checked),
		.play_done         (play_done)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// ------------------------------------------------------------------
	// table building with a model that follows the bus rules
	// ------------------------------------------------------------------
	task automatic add_step(input logic rd, input logic sel, input bus_word_t value,
		input bus_word_t expected, input label_t name);
		steps.push_back('{rd, sel, value, expected, name});
	endtask

	task automatic add_address(input word_address_t address, input label_t name);
		model_address = address;
		add_step(1'b0, 1'b0, bus_word_t'(address), '0, name);
	endtask

	task automatic add_word(input label_t name);
		data_word_t word;
		word = next_random();
		model_memory[model_address] = word;
		add_step(1'b0, 1'b1, word[31:16], '0, name); // high halfword first
		add_step(1'b0, 1'b1, word[15:0], '0, name);
		model_address++;
	endtask

	task automatic add_stray(input label_t name);
		data_word_t word;
		word = next_random();
		add_step(1'b0, 1'b1, word[15:0], '0, name); // lost to the next address
	endtask

	task automatic add_read_word(input label_t name);
		add_step(1'b1, 1'b1, '0, model_memory[model_address][31:16], name);
		add_step(1'b1, 1'b1, '0, model_memory[model_address][15:0], name);
		expected_reads += 2;
		model_address++;
	endtask

	task automatic build_table();
		add_address(8'h20, "single_word");
		add_word("single_word");
		add_address(8'h20, "single_word");
		add_read_word("single_word");
		add_address(8'h40, "autoincrement");
		repeat (4) add_word("autoincrement");
		add_address(8'h40, "autoincrement");
		repeat (4) add_read_word("autoincrement");
		add_stray("abort");
		add_address(8'h61, "abort");
		add_word("abort");
		add_address(8'h61, "abort");
		add_read_word("abort");
		add_address(8'h00, "playback_fill"); // words 0 to 15 feed the loop
		repeat (16) add_word("playback_fill");
	endtask

	task automatic wait_ack(input logic level);
		do @(negedge clock); while (ack_valid !== level);
	endtask

	task automatic run_step(input step_t step);
		@(posedge clock);
		read <= step.read;
		register_select <= step.register_select;
		bus_in <= step.value;
		expected_halfword <= step.expected;
		current_name <= step.name;
		enable <= 1'b1;
		wait_ack(1'b1);
		@(posedge clock);
		enable <= 1'b0;
		wait_ack(1'b0); // bus held until the ack drops
	endtask

	task automatic fill_play_image();
		data_word_t word;
		for (int b = 0; b < play_end_byte - play_start_byte; b++) begin
			word = model_memory[(play_start_byte + b) / 4];
			play_image[b*8 +: 8] = word[((play_start_byte + b) % 4)*8 +: 8]; // low byte first
		end
	endtask

	// ------------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------------
	initial begin
		reset125 = 1'b1;
		read = 1'b0;
		register_select = 1'b0;
		enable = 1'b0;
		bus_in = '0;
		expected_halfword = '0;
		current_name = "after_reset";
		play_arm = 1'b0;
		play_image = '0;
		table_ready = 1'b0;
		lcg_state = 32'hf544;
		model_address = '0;
		expected_reads = 0;
		count_errors = 0;
		build_table();
		table_ready = 1'b1;
		repeat (10) @(posedge clock);
		reset125 <= 1'b0;
		repeat (20) @(posedge clock); // quiet window after reset
		foreach (steps[i]) begin
			run_step(steps[i]);
		end
		fill_play_image();
		@(posedge clock);
		play_arm <= 1'b1;
		do @(negedge clock); while (play_done !== 1'b1);
		if (reads_checked != expected_reads) begin
			$display("only %0d of %0d reads were acknowledged and checked",
				reads_checked, expected_reads);
			count_errors++;
		end
		$display("errors: after_reset %0d, readback %0d, playback %0d, sync %0d, read count %0d",
			idle_errors, read_errors, play_errors, sync_errors, count_errors);
		if (idle_errors + read_errors + play_errors + sync_errors + count_errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	// watchdog
	initial begin
		wait (table_ready === 1'b1);
		repeat (steps.size() * 200 + 1000) @(posedge clock);
		$display("timeout: the run did not finish within %0d cycles", steps.size() * 200 + 1000);
		$display("Testbench failed");
		$finish;
	end

endmodule

/* pollable_memory.f */
design/pollable_memory_pkg.sv
design/bus_input_filter.sv
design/bus_transaction_fsm.sv
design/word_assembler.sv
design/gearbox_ram.sv
design/playback_counter.sv
design/pollable_memory.sv
testbench/pollable_memory_checker.sv
testbench/pollable_memory_tb.sv
